//--- wb_interconnect.f
hw/wb_bus_pkg.sv
hw/ic_map_pkg.sv
hw/wb_master_decoder.sv
hw/wb_rr_arbiter.sv
hw/wb_target_mux.sv
hw/wb_resp_router.sv
hw/wb_decode_err_target.sv
hw/wb_interconnect_4x2.sv
verification/wb_mem_target_model.sv
verification/tb_wb_interconnect.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_wb_interconnect \
	-f wb_interconnect.f -o sim_wb_interconnect \
	&& ./obj_dir/sim_wb_interconnect > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "RESULT: build or run error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "RESULT: fail"; exit 1; } \
	|| { echo "RESULT: pass"; exit 0; }

//--- verification/tb_wb_interconnect.sv
`timescale 1ns/1ps

module tb_wb_interconnect;

	localparam int TIMEOUT_CYCLES = 200;
	localparam wb_bus_pkg::wb_addr_t BAD_ADR = 32'h0002_0000;
	localparam wb_bus_pkg::wb_addr_t RR_OFFSET = 32'h0000_0200;

	logic clk;
	logic rstn;
	logic                 m_cyc_i [ic_map_pkg::N_MASTERS];
	logic                 m_stb_i [ic_map_pkg::N_MASTERS];
	logic                 m_we_i  [ic_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_addr_t m_adr_i [ic_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_data_t m_dat_i [ic_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_sel_t  m_sel_i [ic_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_cti_t  m_cti_i [ic_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_bte_t  m_bte_i [ic_map_pkg::N_MASTERS];
	logic                 m_ack_o [ic_map_pkg::N_MASTERS];
	logic                 m_err_o [ic_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_data_t m_dat_o [ic_map_pkg::N_MASTERS];
	logic s0_cyc_o, s0_stb_o, s0_we_o, s0_ack_i, s0_err_i;
	logic s1_cyc_o, s1_stb_o, s1_we_o, s1_ack_i, s1_err_i;
	wb_bus_pkg::wb_addr_t s0_adr_o, s1_adr_o;
	wb_bus_pkg::wb_data_t s0_dat_o, s1_dat_o, s0_dat_i, s1_dat_i;
	wb_bus_pkg::wb_sel_t  s0_sel_o, s1_sel_o;
	wb_bus_pkg::wb_cti_t  s0_cti_o, s1_cti_o;
	wb_bus_pkg::wb_bte_t  s0_bte_o, s1_bte_o;

	int checks;
	int errors;
	int test_errs;
	int stray_cnt;
	bit watch_s0;
	bit watch_stray;
	logic [15:0] lfsr;
	ic_map_pkg::master_id_t rr_last;
	ic_map_pkg::master_id_t grant_q [$];
	wb_bus_pkg::wb_data_t shadow [wb_bus_pkg::wb_addr_t];
	time s0_done [ic_map_pkg::N_MASTERS];
	time s1_done;

	wb_interconnect_4x2 uut (.*);

	wb_mem_target_model #(.BASE(ic_map_pkg::SLV0_BASE), .DEPTH(1024)) u_s0 (
		.clk(clk), .rstn(rstn), .cyc_i(s0_cyc_o), .stb_i(s0_stb_o), .we_i(s0_we_o),
		.adr_i(s0_adr_o), .dat_i(s0_dat_o), .sel_i(s0_sel_o),
		.ack_o(s0_ack_i), .err_o(s0_err_i), .dat_o(s0_dat_i)
	);
	wb_mem_target_model #(.BASE(ic_map_pkg::SLV1_BASE), .DEPTH(1024)) u_s1 (
		.clk(clk), .rstn(rstn), .cyc_i(s1_cyc_o), .stb_i(s1_stb_o), .we_i(s1_we_o),
		.adr_i(s1_adr_o), .dat_i(s1_dat_o), .sel_i(s1_sel_o),
		.ack_o(s1_ack_i), .err_o(s1_err_i), .dat_o(s1_dat_i)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Count strobes during unmapped accesses and record the order in which slave 0 finishes
	always @(negedge clk) begin
		if (watch_stray && (s0_stb_o || s1_stb_o)) begin
			stray_cnt++;
		end
		if (watch_s0 && s0_ack_i) begin
			grant_q.push_back(ic_map_pkg::master_id_t'((s0_adr_o - RR_OFFSET) >> 2));
		end
	end

	// 16-bit Galois LFSR stepped once per bit taken
	function automatic wb_bus_pkg::wb_data_t take_bits(input int n);
		wb_bus_pkg::wb_data_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic wb_bus_pkg::wb_data_t merge_bytes(input wb_bus_pkg::wb_data_t old,
			input wb_bus_pkg::wb_data_t nw, input wb_bus_pkg::wb_sel_t sel);
		wb_bus_pkg::wb_data_t r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				r[b*8 +: 8] = nw[b*8 +: 8];
			end
		end
		return r;
	endfunction

	// Expected read data from the address map and the shadow memory
	function automatic wb_bus_pkg::wb_data_t ref_read(input wb_bus_pkg::wb_addr_t adr,
			output bit exp_err);
		wb_bus_pkg::wb_addr_t wa;
		wa = {adr[31:2], 2'b00};
		exp_err = !((adr >= ic_map_pkg::SLV0_BASE && adr <= ic_map_pkg::SLV0_LIMIT) ||
			(adr >= ic_map_pkg::SLV1_BASE && adr <= ic_map_pkg::SLV1_LIMIT));
		if (exp_err) begin
			return '0;
		end
		if (shadow.exists(wa)) begin
			return shadow[wa];
		end
		return ~wa;
	endfunction

	// Lowest pending master above prev or else the lowest pending one
	function automatic ic_map_pkg::master_id_t next_rr(input logic [3:0] pend,
			input ic_map_pkg::master_id_t prev);
		ic_map_pkg::master_id_t pick;
		bit found;
		pick = '0;
		found = 1'b0;
		for (int i = 0; i < ic_map_pkg::N_MASTERS; i++) begin
			if (!found && pend[i] && i > int'(prev)) begin
				pick = ic_map_pkg::master_id_t'(i);
				found = 1'b1;
			end
		end
		for (int i = 0; i < ic_map_pkg::N_MASTERS; i++) begin
			if (!found && pend[i]) begin
				pick = ic_map_pkg::master_id_t'(i);
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	task automatic check_data(input string what, input wb_bus_pkg::wb_data_t got,
			input wb_bus_pkg::wb_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_err(input string what, input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("mismatch at %0t: %s got %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	task automatic check_id(input string what, input ic_map_pkg::master_id_t got,
			input ic_map_pkg::master_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("mismatch at %0t: %s got master %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_tags(input string what, input wb_bus_pkg::wb_cti_t got_cti,
			input wb_bus_pkg::wb_bte_t got_bte, input wb_bus_pkg::wb_cti_t exp_cti,
			input wb_bus_pkg::wb_bte_t exp_bte);
		checks++;
		if (got_cti !== exp_cti || got_bte !== exp_bte) begin
			errors++;
			test_errs++;
			$display("mismatch at %0t: %s got cti %0d bte %0d, expected cti %0d bte %0d",
				$time, what, got_cti, got_bte, exp_cti, exp_bte);
		end
	endtask

	task automatic plain_fail(input string msg);
		errors++;
		test_errs++;
		$display("%s", msg);
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "failed", test_errs);
		test_errs = 0;
	endtask

	// One classic cycle held until ACK or ERR
	task automatic do_xfer(input ic_map_pkg::master_id_t m, input bit we,
			input wb_bus_pkg::wb_addr_t adr, input wb_bus_pkg::wb_data_t dat,
			input wb_bus_pkg::wb_sel_t sel, output wb_bus_pkg::wb_data_t rdat,
			output bit got_ack, output bit got_err);
		int cnt;
		bit seen;
		bit dummy;
		wb_bus_pkg::wb_data_t old;
		wb_bus_pkg::wb_cti_t cti;
		wb_bus_pkg::wb_bte_t bte;
		@(posedge clk);
		#1;
		// Burst tags vary per transfer so the slave side can show they pass through
		cti = wb_bus_pkg::wb_cti_t'(adr[4:2]);
		bte = wb_bus_pkg::wb_bte_t'(m);
		m_cyc_i[m] = 1'b1;
		m_stb_i[m] = 1'b1;
		m_we_i[m] = we;
		m_adr_i[m] = adr;
		m_dat_i[m] = dat;
		m_sel_i[m] = sel;
		m_cti_i[m] = cti;
		m_bte_i[m] = bte;
		seen = 1'b0;
		cnt = 0;
		while (!seen && cnt < TIMEOUT_CYCLES) begin
			@(negedge clk);
			seen = m_ack_o[m] || m_err_o[m];
			cnt++;
		end
		got_ack = m_ack_o[m];
		got_err = m_err_o[m];
		rdat = m_dat_o[m];
		if (!seen) begin
			plain_fail($sformatf("timeout: master %0d saw no ACK or ERR for adr %h", m, adr));
		end
		// The acking slave still sees this master's request here
		if (got_ack && adr <= ic_map_pkg::SLV0_LIMIT) begin
			check_tags("s0 burst tags", s0_cti_o, s0_bte_o, cti, bte);
		end else if (got_ack) begin
			check_tags("s1 burst tags", s1_cti_o, s1_bte_o, cti, bte);
		end
		if (we && got_ack) begin
			old = ref_read(adr, dummy);
			shadow[{adr[31:2], 2'b00}] = merge_bytes(old, dat, sel);
		end
		if (got_ack && adr <= ic_map_pkg::SLV0_LIMIT) begin
			rr_last = m;
		end
		@(posedge clk);
		#1;
		m_cyc_i[m] = 1'b0;
		m_stb_i[m] = 1'b0;
		m_we_i[m] = 1'b0;
	endtask

	task automatic read_check(input ic_map_pkg::master_id_t m, input wb_bus_pkg::wb_addr_t adr,
			input string what);
		wb_bus_pkg::wb_data_t exp;
		wb_bus_pkg::wb_data_t rd;
		bit exp_err;
		bit a;
		bit e;
		exp = ref_read(adr, exp_err);
		do_xfer(m, 1'b0, adr, '0, '1, rd, a, e);
		check_data(what, rd, exp);
		check_err({what, " err"}, e, exp_err);
		check_err({what, " ack"}, a, !exp_err);
	endtask

	// One of four masters racing for slave 0; the first winner then goes to slave 1
	task automatic contend(input ic_map_pkg::master_id_t m, input ic_map_pkg::master_id_t first);
		wb_bus_pkg::wb_data_t rd;
		bit a;
		bit e;
		do_xfer(m, 1'b1, RR_OFFSET + wb_bus_pkg::wb_addr_t'({m, 2'b00}),
			{16'hC0DE, 14'h0, m}, 4'hF, rd, a, e);
		s0_done[m] = $time;
		check_err("contender ack", a, 1'b1);
		if (m == first) begin
			do_xfer(m, 1'b1, ic_map_pkg::SLV1_BASE + 32'h300, 32'h5151_0000, 4'hF, rd, a, e);
			s1_done = $time;
			check_err("slave 1 ack during contention", a, 1'b1);
		end
	endtask

	initial begin
		wb_bus_pkg::wb_addr_t adr;
		wb_bus_pkg::wb_data_t rd;
		wb_bus_pkg::wb_sel_t sel;
		ic_map_pkg::master_id_t first;
		ic_map_pkg::master_id_t prev;
		ic_map_pkg::master_id_t exp_id;
		logic [3:0] pend;
		time last_s0;
		bit a;
		bit e;

		rstn = 1'b0;
		for (int m = 0; m < ic_map_pkg::N_MASTERS; m++) begin
			m_cyc_i[m] = 1'b0;
			m_stb_i[m] = 1'b0;
			m_we_i[m] = 1'b0;
			m_adr_i[m] = '0;
			m_dat_i[m] = '0;
			m_sel_i[m] = '0;
			m_cti_i[m] = '0;
			m_bte_i[m] = '0;
		end
		lfsr = 16'd49;
		checks = 0;
		errors = 0;
		test_errs = 0;
		stray_cnt = 0;
		watch_s0 = 1'b0;
		watch_stray = 1'b0;
		rr_last = ic_map_pkg::master_id_t'(3);
		s1_done = 0;
		repeat (2) @(posedge clk);
		#1;
		rstn = 1'b1;

		@(negedge clk);
		check_err("s0_cyc_o", s0_cyc_o, 1'b0);
		check_err("s0_stb_o", s0_stb_o, 1'b0);
		check_err("s1_cyc_o", s1_cyc_o, 1'b0);
		check_err("s1_stb_o", s1_stb_o, 1'b0);
		for (int m = 0; m < ic_map_pkg::N_MASTERS; m++) begin
			check_err("m_ack_o", m_ack_o[m], 1'b0);
			check_err("m_err_o", m_err_o[m], 1'b0);
		end
		end_test("reset");

		for (int m = 0; m < ic_map_pkg::N_MASTERS; m++) begin
			for (int s = 0; s < 2; s++) begin
				for (int i = 0; i < 4; i++) begin
					adr = (s == 0) ? ic_map_pkg::SLV0_BASE : ic_map_pkg::SLV1_BASE;
					adr = adr + wb_bus_pkg::wb_addr_t'(m * 64 + i * 4);
					do_xfer(ic_map_pkg::master_id_t'(m), 1'b1, adr, take_bits(32), 4'hF, rd, a, e);
					check_err("write ack", a, 1'b1);
					read_check(ic_map_pkg::master_id_t'(m), adr, "readback");
				end
			end
		end
		end_test("write and read back");

		for (int m = 0; m < ic_map_pkg::N_MASTERS; m++) begin
			adr = (m % 2 == 0) ? ic_map_pkg::SLV0_BASE : ic_map_pkg::SLV1_BASE;
			adr = adr + 32'h800 + wb_bus_pkg::wb_addr_t'(m * 4);
			do_xfer(ic_map_pkg::master_id_t'(m), 1'b1, adr, take_bits(32), 4'hF, rd, a, e);
			sel = wb_bus_pkg::wb_sel_t'(take_bits(4));
			if (sel == 4'h0 || sel == 4'hF) begin
				sel = 4'b0110;
			end
			do_xfer(ic_map_pkg::master_id_t'(m), 1'b1, adr, take_bits(32), sel, rd, a, e);
			check_err("partial write ack", a, 1'b1);
			read_check(ic_map_pkg::master_id_t'(m), adr, "partial readback");
		end
		end_test("byte select");

		stray_cnt = 0;
		watch_stray = 1'b1;
		for (int m = 0; m < ic_map_pkg::N_MASTERS; m++) begin
			adr = BAD_ADR + wb_bus_pkg::wb_addr_t'(m * 4);
			read_check(ic_map_pkg::master_id_t'(m), adr, "unmapped read");
			do_xfer(ic_map_pkg::master_id_t'(m), 1'b1, adr, 32'hDEAD_BEEF, 4'hF, rd, a, e);
			check_err("unmapped write err", e, 1'b1);
			check_err("unmapped write ack", a, 1'b0);
		end
		watch_stray = 1'b0;
		check_err("slave strobe during unmapped access", stray_cnt != 0, 1'b0);
		end_test("unmapped address");

		first = next_rr(4'hF, rr_last);
		prev = rr_last;
		grant_q.delete();
		watch_s0 = 1'b1;
		fork
			contend(ic_map_pkg::master_id_t'(0), first);
			contend(ic_map_pkg::master_id_t'(1), first);
			contend(ic_map_pkg::master_id_t'(2), first);
			contend(ic_map_pkg::master_id_t'(3), first);
		join
		watch_s0 = 1'b0;
		if (grant_q.size() != ic_map_pkg::N_MASTERS) begin
			plain_fail($sformatf("slave 0 finished %0d transfers instead of 4", grant_q.size()));
		end
		pend = 4'hF;
		last_s0 = 0;
		for (int k = 0; k < ic_map_pkg::N_MASTERS; k++) begin
			exp_id = next_rr(pend, prev);
			if (k < grant_q.size()) begin
				check_id("grant order", grant_q[k], exp_id);
			end
			pend[exp_id] = 1'b0;
			prev = exp_id;
			if (s0_done[k] > last_s0) begin
				last_s0 = s0_done[k];
			end
		end
		if (s1_done == 0 || s1_done >= last_s0) begin
			plain_fail("the slave 1 transfer did not finish ahead of the slave 0 traffic");
		end
		end_test("contention");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- verification/wb_mem_target_model.sv
`timescale 1ns/1ps

module wb_mem_target_model #(
	parameter wb_bus_pkg::wb_addr_t BASE = '0,
	parameter int DEPTH = 1024
) (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  wb_bus_pkg::wb_addr_t adr_i,
	input  wb_bus_pkg::wb_data_t dat_i,
	input  wb_bus_pkg::wb_sel_t  sel_i,
	output logic                 ack_o,
	output logic                 err_o,
	output wb_bus_pkg::wb_data_t dat_o
);

	localparam int AW = $clog2(DEPTH);

	wb_bus_pkg::wb_data_t mem [DEPTH];
	logic [AW-1:0] idx;

	assign idx = adr_i[AW+1:2];
	assign err_o = 1'b0;

	// Each word starts as the inverse of its own byte address
	initial begin
		ack_o = 1'b0;
		dat_o = '0;
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = ~(BASE + wb_bus_pkg::wb_addr_t'(i * 4));
		end
	end

	// ACK one edge after the strobe, dropped on the next edge
	always @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
			dat_o <= '0;
		end else begin
			ack_o <= cyc_i && stb_i && !ack_o;
			if (cyc_i && stb_i && !ack_o) begin
				if (we_i) begin
					for (int b = 0; b < 4; b++) begin
						if (sel_i[b]) begin
							mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
						end
					end
				end else begin
					dat_o <= mem[idx];
				end
			end
		end
	end

endmodule

//--- hw/wb_interconnect_4x2.sv
`timescale 1ns/1ps

module wb_interconnect_4x2 (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 m_cyc_i [ic_map_pkg::N_MASTERS],
	input  logic                 m_stb_i [ic_map_pkg::N_MASTERS],
	input  logic                 m_we_i  [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_addr_t m_adr_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_data_t m_dat_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_sel_t  m_sel_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_cti_t  m_cti_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_bte_t  m_bte_i [ic_map_pkg::N_MASTERS],
	output logic                 m_ack_o [ic_map_pkg::N_MASTERS],
	output logic                 m_err_o [ic_map_pkg::N_MASTERS],
	output wb_bus_pkg::wb_data_t m_dat_o [ic_map_pkg::N_MASTERS],
	output logic                 s0_cyc_o,
	output logic                 s0_stb_o,
	output logic                 s0_we_o,
	output wb_bus_pkg::wb_addr_t s0_adr_o,
	output wb_bus_pkg::wb_data_t s0_dat_o,
	output wb_bus_pkg::wb_sel_t  s0_sel_o,
	output wb_bus_pkg::wb_cti_t  s0_cti_o,
	output wb_bus_pkg::wb_bte_t  s0_bte_o,
	input  logic                 s0_ack_i,
	input  logic                 s0_err_i,
	input  wb_bus_pkg::wb_data_t s0_dat_i,
	output logic                 s1_cyc_o,
	output logic                 s1_stb_o,
	output logic                 s1_we_o,
	output wb_bus_pkg::wb_addr_t s1_adr_o,
	output wb_bus_pkg::wb_data_t s1_dat_o,
	output wb_bus_pkg::wb_sel_t  s1_sel_o,
	output wb_bus_pkg::wb_cti_t  s1_cti_o,
	output wb_bus_pkg::wb_bte_t  s1_bte_o,
	input  logic                 s1_ack_i,
	input  logic                 s1_err_i,
	input  wb_bus_pkg::wb_data_t s1_dat_i
);

	ic_map_pkg::target_id_t sel_target [ic_map_pkg::N_MASTERS];
	logic [ic_map_pkg::N_MASTERS-1:0] req [ic_map_pkg::N_TARGETS];
	logic                   gnt    [ic_map_pkg::N_TARGETS];
	ic_map_pkg::master_id_t gnt_id [ic_map_pkg::N_TARGETS];

	// Response side of each target, index 2 is the error target
	logic                 t_ack [ic_map_pkg::N_TARGETS];
	logic                 t_err [ic_map_pkg::N_TARGETS];
	wb_bus_pkg::wb_data_t t_dat [ic_map_pkg::N_TARGETS];

	// Request stage 1, decode per master, with the return path beside it
	for (genvar m = 0; m < ic_map_pkg::N_MASTERS; m++) begin : g_master
		wb_master_decoder u_dec (
			.clk          (clk),
			.rstn         (rstn),
			.cyc_i        (m_cyc_i[m]),
			.stb_i        (m_stb_i[m]),
			.adr_i        (m_adr_i[m]),
			.ack_i        (m_ack_o[m]),
			.err_i        (m_err_o[m]),
			.sel_target_o (sel_target[m])
		);

		wb_resp_router u_rtr (
			.sel_target_i (sel_target[m]),
			.self_id_i    (ic_map_pkg::master_id_t'(m)),
			.gnt_i        (gnt),
			.gnt_id_i     (gnt_id),
			.t_ack_i      (t_ack),
			.t_err_i      (t_err),
			.t_dat_i      (t_dat),
			.ack_o        (m_ack_o[m]),
			.err_o        (m_err_o[m]),
			.dat_o        (m_dat_o[m])
		);

		for (genvar t = 0; t < ic_map_pkg::N_TARGETS; t++) begin : g_req
			assign req[t][m] = (sel_target[m] == ic_map_pkg::target_id_t'(t));
		end
	end

	// Stage 2 arbitration, stage 3 target multiplexing
	wb_rr_arbiter #(.N_REQ(ic_map_pkg::N_MASTERS)) u_arb0 (
		.clk(clk), .rstn(rstn), .req_i(req[0]), .gnt_o(gnt[0]), .gnt_id_o(gnt_id[0])
	);
	wb_rr_arbiter #(.N_REQ(ic_map_pkg::N_MASTERS)) u_arb1 (
		.clk(clk), .rstn(rstn), .req_i(req[1]), .gnt_o(gnt[1]), .gnt_id_o(gnt_id[1])
	);
	wb_rr_arbiter #(.N_REQ(ic_map_pkg::N_MASTERS)) u_arb_err (
		.clk(clk), .rstn(rstn), .req_i(req[2]), .gnt_o(gnt[2]), .gnt_id_o(gnt_id[2])
	);

	wb_target_mux u_mux0 (
		.m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i), .m_we_i(m_we_i), .m_adr_i(m_adr_i),
		.m_dat_i(m_dat_i), .m_sel_i(m_sel_i), .m_cti_i(m_cti_i), .m_bte_i(m_bte_i),
		.gnt_i(gnt[0]), .gnt_id_i(gnt_id[0]),
		.t_cyc_o(s0_cyc_o), .t_stb_o(s0_stb_o), .t_we_o(s0_we_o), .t_adr_o(s0_adr_o),
		.t_dat_o(s0_dat_o), .t_sel_o(s0_sel_o), .t_cti_o(s0_cti_o), .t_bte_o(s0_bte_o)
	);

	wb_target_mux u_mux1 (
		.m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i), .m_we_i(m_we_i), .m_adr_i(m_adr_i),
		.m_dat_i(m_dat_i), .m_sel_i(m_sel_i), .m_cti_i(m_cti_i), .m_bte_i(m_bte_i),
		.gnt_i(gnt[1]), .gnt_id_i(gnt_id[1]),
		.t_cyc_o(s1_cyc_o), .t_stb_o(s1_stb_o), .t_we_o(s1_we_o), .t_adr_o(s1_adr_o),
		.t_dat_o(s1_dat_o), .t_sel_o(s1_sel_o), .t_cti_o(s1_cti_o), .t_bte_o(s1_bte_o)
	);

	// The error target only looks at CYC and STB
	logic err_cyc;
	logic err_stb;

	wb_target_mux u_mux_err (
		.m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i), .m_we_i(m_we_i), .m_adr_i(m_adr_i),
		.m_dat_i(m_dat_i), .m_sel_i(m_sel_i), .m_cti_i(m_cti_i), .m_bte_i(m_bte_i),
		.gnt_i(gnt[2]), .gnt_id_i(gnt_id[2]),
		.t_cyc_o(err_cyc), .t_stb_o(err_stb), .t_we_o(), .t_adr_o(),
		.t_dat_o(), .t_sel_o(), .t_cti_o(), .t_bte_o()
	);

	wb_decode_err_target u_err (
		.clk   (clk),
		.rstn  (rstn),
		.cyc_i (err_cyc),
		.stb_i (err_stb),
		.ack_o (t_ack[2]),
		.err_o (t_err[2]),
		.dat_o (t_dat[2])
	);

	assign t_ack[0] = s0_ack_i;
	assign t_err[0] = s0_err_i;
	assign t_dat[0] = s0_dat_i;
	assign t_ack[1] = s1_ack_i;
	assign t_err[1] = s1_err_i;
	assign t_dat[1] = s1_dat_i;

endmodule

//--- hw/wb_decode_err_target.sv
`timescale 1ns/1ps

module wb_decode_err_target (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	output logic                 ack_o,
	output logic                 err_o,
	output wb_bus_pkg::wb_data_t dat_o
);

	logic err_q;

	// One ERR pulse per strobe, never back to back
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= cyc_i && stb_i && !err_q;
		end
	end

	assign err_o = err_q;
	assign ack_o = 1'b0;
	assign dat_o = '0;

endmodule

//--- hw/wb_resp_router.sv
`timescale 1ns/1ps

module wb_resp_router (
	input  ic_map_pkg::target_id_t sel_target_i,
	input  ic_map_pkg::master_id_t self_id_i,
	input  logic                   gnt_i    [ic_map_pkg::N_TARGETS],
	input  ic_map_pkg::master_id_t gnt_id_i [ic_map_pkg::N_TARGETS],
	input  logic                   t_ack_i  [ic_map_pkg::N_TARGETS],
	input  logic                   t_err_i  [ic_map_pkg::N_TARGETS],
	input  wb_bus_pkg::wb_data_t   t_dat_i  [ic_map_pkg::N_TARGETS],
	output logic                   ack_o,
	output logic                   err_o,
	output wb_bus_pkg::wb_data_t   dat_o
);

	always_comb begin
		ack_o = 1'b0;
		err_o = 1'b0;
		dat_o = '0;
		// Only the owner of the selected target sees its response
		if (sel_target_i != ic_map_pkg::NO_TARGET) begin
			if (gnt_i[sel_target_i] && gnt_id_i[sel_target_i] == self_id_i) begin
				ack_o = t_ack_i[sel_target_i];
				err_o = t_err_i[sel_target_i];
				dat_o = t_dat_i[sel_target_i];
			end
		end
	end

endmodule

//--- hw/wb_target_mux.sv
`timescale 1ns/1ps

module wb_target_mux (
	input  logic                   m_cyc_i [ic_map_pkg::N_MASTERS],
	input  logic                   m_stb_i [ic_map_pkg::N_MASTERS],
	input  logic                   m_we_i  [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_addr_t   m_adr_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_data_t   m_dat_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_sel_t    m_sel_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_cti_t    m_cti_i [ic_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_bte_t    m_bte_i [ic_map_pkg::N_MASTERS],
	input  logic                   gnt_i,
	input  ic_map_pkg::master_id_t gnt_id_i,
	output logic                   t_cyc_o,
	output logic                   t_stb_o,
	output logic                   t_we_o,
	output wb_bus_pkg::wb_addr_t   t_adr_o,
	output wb_bus_pkg::wb_data_t   t_dat_o,
	output wb_bus_pkg::wb_sel_t    t_sel_o,
	output wb_bus_pkg::wb_cti_t    t_cti_o,
	output wb_bus_pkg::wb_bte_t    t_bte_o
);

	// Idle bus when no master owns this target
	always_comb begin
		t_cyc_o = 1'b0;
		t_stb_o = 1'b0;
		t_we_o = 1'b0;
		t_adr_o = '0;
		t_dat_o = '0;
		t_sel_o = '0;
		t_cti_o = '0;
		t_bte_o = '0;
		if (gnt_i) begin
			t_cyc_o = m_cyc_i[gnt_id_i];
			t_stb_o = m_stb_i[gnt_id_i];
			t_we_o = m_we_i[gnt_id_i];
			t_adr_o = m_adr_i[gnt_id_i];
			t_dat_o = m_dat_i[gnt_id_i];
			t_sel_o = m_sel_i[gnt_id_i];
			t_cti_o = m_cti_i[gnt_id_i];
			t_bte_o = m_bte_i[gnt_id_i];
		end
	end

endmodule

//--- hw/wb_rr_arbiter.sv
`timescale 1ns/1ps

module wb_rr_arbiter #(
	parameter int N_REQ = ic_map_pkg::N_MASTERS
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic [N_REQ-1:0]       req_i,
	output logic                   gnt_o,
	output ic_map_pkg::master_id_t gnt_id_o
);

	logic                   found_above;
	logic                   found_any;
	ic_map_pkg::master_id_t pick_above;
	ic_map_pkg::master_id_t pick_any;
	ic_map_pkg::master_id_t next_id;

	// Scan downwards so the lowest matching index wins
	always_comb begin
		found_above = 1'b0;
		found_any = 1'b0;
		pick_above = '0;
		pick_any = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				found_any = 1'b1;
				pick_any = ic_map_pkg::master_id_t'(i);
				if (i > int'(gnt_id_o)) begin
					found_above = 1'b1;
					pick_above = ic_map_pkg::master_id_t'(i);
				end
			end
		end
		// Wrap to the lowest requester when nobody sits above the last grant
		next_id = found_above ? pick_above : pick_any;
	end

	// gnt_id_o keeps the last granted index while idle
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o <= 1'b0;
			gnt_id_o <= ic_map_pkg::master_id_t'(N_REQ - 1);
		end else if (gnt_o) begin
			if (!req_i[gnt_id_o]) begin
				gnt_o <= 1'b0;
			end
		end else if (found_any) begin
			gnt_o <= 1'b1;
			gnt_id_o <= next_id;
		end
	end

endmodule

//--- hw/wb_master_decoder.sv
`timescale 1ns/1ps

module wb_master_decoder (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  wb_bus_pkg::wb_addr_t   adr_i,
	input  logic                   ack_i,
	input  logic                   err_i,
	output ic_map_pkg::target_id_t sel_target_o
);

	ic_map_pkg::dec_state_e state;
	ic_map_pkg::target_id_t addr_target;

	// Fixed address map lookup
	always_comb begin
		if (adr_i >= ic_map_pkg::SLV0_BASE && adr_i <= ic_map_pkg::SLV0_LIMIT) begin
			addr_target = ic_map_pkg::target_id_t'(0);
		end else if (adr_i >= ic_map_pkg::SLV1_BASE && adr_i <= ic_map_pkg::SLV1_LIMIT) begin
			addr_target = ic_map_pkg::target_id_t'(1);
		end else begin
			addr_target = ic_map_pkg::ERR_TARGET;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ic_map_pkg::DEC_IDLE;
			sel_target_o <= ic_map_pkg::NO_TARGET;
		end else begin
			case (state)
				ic_map_pkg::DEC_IDLE: begin
					// Target is latched once per cycle and held until the response
					if (cyc_i && stb_i) begin
						state <= ic_map_pkg::DEC_WAIT;
						sel_target_o <= addr_target;
					end
				end
				ic_map_pkg::DEC_WAIT: begin
					if (ack_i || err_i) begin
						state <= ic_map_pkg::DEC_IDLE;
						sel_target_o <= ic_map_pkg::NO_TARGET;
					end
				end
				default: begin
					state <= ic_map_pkg::DEC_IDLE;
					sel_target_o <= ic_map_pkg::NO_TARGET;
				end
			endcase
		end
	end

endmodule

//--- hw/ic_map_pkg.sv
package ic_map_pkg;

	localparam int N_MASTERS = 4;
	// Targets 0 and 1 are external, target 2 answers unmapped addresses
	localparam int N_TARGETS = 3;

	typedef logic [$clog2(N_MASTERS)-1:0] master_id_t;
	typedef logic [1:0] target_id_t;

	localparam target_id_t ERR_TARGET = 2'd2;
	localparam target_id_t NO_TARGET = 2'd3;

	// Inclusive address windows
	localparam wb_bus_pkg::wb_addr_t SLV0_BASE = 32'h0000_0000;
	localparam wb_bus_pkg::wb_addr_t SLV0_LIMIT = 32'h0000_0FFF;
	localparam wb_bus_pkg::wb_addr_t SLV1_BASE = 32'h0001_0000;
	localparam wb_bus_pkg::wb_addr_t SLV1_LIMIT = 32'h0001_0FFF;

	typedef enum logic {
		DEC_IDLE,
		DEC_WAIT
	} dec_state_e;

endpackage

//--- hw/wb_bus_pkg.sv
package wb_bus_pkg;

	// Wishbone classic bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [SEL_W-1:0] wb_sel_t;

	// Burst tags, carried through unchanged
	typedef logic [2:0] wb_cti_t;
	typedef logic [1:0] wb_bte_t;

endpackage
